// File: include/usonic_defines.svh
/* sizes of the drive controller. USN_WIDTH sets both the duty resolution
   and the PWM period of 2**USN_WIDTH clocks. */
`ifndef USONIC_DEFINES_SVH
`define USONIC_DEFINES_SVH

// number of transducer outputs.
`define USN_NUM_XDCR 8

// duty and phase width.
`define USN_WIDTH 8

// modulation table entries, a power of two.
`define USN_MOD_DEPTH 16

// AXI4-Lite byte address width.
`define USN_ADDR_W 12

`endif

// File: sim/usonic_tb.sv
/* directed testbench for usonic_top; pins are sampled on the falling edge.
   pin windows are 256 samples, the PWM period at USN_WIDTH of 8. */
`timescale 1ns/100ps
`include "usonic_defines.svh"

module usonic_tb;

  localparam int W = `USN_WIDTH;
  localparam int N = `USN_NUM_XDCR;
  localparam int PERIOD = 1 << `USN_WIDTH;
  localparam int TIMEOUT = 1000;

  logic                   clk_l;
  logic                   arst_n;
  logic [`USN_ADDR_W-1:0] awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [31:0]            wdata;
  logic [3:0]             wstrb;
  logic                   wvalid;
  logic                   wready;
  logic [1:0]             bresp;
  logic                   bvalid;
  logic                   bready;
  logic [`USN_ADDR_W-1:0] araddr;
  logic                   arvalid;
  logic                   arready;
  logic [31:0]            rdata;
  logic [1:0]             rresp;
  logic                   rvalid;
  logic                   rready;
  logic [N-1:0]           xdcr_out;
  logic [31:0]            rng_state;
  logic [W-1:0]           duty_prog [N];

  usonic_top usonic_top_inst (.*);

  always #5 clk_l = ~clk_l;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic wait_expired(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    stop_run();
  endtask

  task automatic check_resp(input usonic_pkg::resp_e got, input usonic_pkg::resp_e exp,
                            input string msg);
    if (got !== exp) report_mismatch($sformatf("%s: resp %0d, expected %0d", msg, got, exp));
  endtask

  task automatic check_duty(input logic [W-1:0] got, input logic [W-1:0] exp,
                            input string msg);
    if (got !== exp) report_mismatch($sformatf("%s: got %0d, expected %0d", msg, got, exp));
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) report_mismatch($sformatf("%s: got 0x%08h, expected 0x%08h", msg, got, exp));
  endtask

  task automatic axi_write(input logic [`USN_ADDR_W-1:0] addr, input logic [31:0] data,
                           output usonic_pkg::resp_e resp);
    int n;
    @(posedge clk_l);
    #1;
    awaddr = addr;
    wdata = data;
    wstrb = 4'hf;
    awvalid = 1'b1;
    wvalid = 1'b1;
    bready = 1'b1;
    n = 0;
    @(negedge clk_l);
    while (!(awready && wready)) begin
      n = n + 1;
      if (n > TIMEOUT) wait_expired("awready and wready");
      @(negedge clk_l);
    end
    @(posedge clk_l);
    #1;
    awvalid = 1'b0;
    wvalid = 1'b0;
    n = 0;
    @(negedge clk_l);
    while (!bvalid) begin
      n = n + 1;
      if (n > TIMEOUT) wait_expired("bvalid");
      @(negedge clk_l);
    end
    resp = usonic_pkg::resp_e'(bresp);
    @(posedge clk_l);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [`USN_ADDR_W-1:0] addr, output logic [31:0] data,
                          output usonic_pkg::resp_e resp);
    int n;
    @(posedge clk_l);
    #1;
    araddr = addr;
    arvalid = 1'b1;
    rready = 1'b1;
    n = 0;
    @(negedge clk_l);
    while (!arready) begin
      n = n + 1;
      if (n > TIMEOUT) wait_expired("arready");
      @(negedge clk_l);
    end
    @(posedge clk_l);
    #1;
    arvalid = 1'b0;
    n = 0;
    @(negedge clk_l);
    while (!rvalid) begin
      n = n + 1;
      if (n > TIMEOUT) wait_expired("rvalid");
      @(negedge clk_l);
    end
    data = rdata;
    resp = usonic_pkg::resp_e'(rresp);
    @(posedge clk_l);
    #1;
    rready = 1'b0;
  endtask

  task automatic write_reg(input logic [`USN_ADDR_W-1:0] addr, input logic [31:0] data);
    usonic_pkg::resp_e resp;
    axi_write(addr, data, resp);
    check_resp(resp, usonic_pkg::OKAY, $sformatf("write 0x%03h", addr));
  endtask

  task automatic read_expect(input logic [`USN_ADDR_W-1:0] addr, input logic [31:0] exp);
    usonic_pkg::resp_e resp;
    logic [31:0]       data;
    axi_read(addr, data, resp);
    check_resp(resp, usonic_pkg::OKAY, $sformatf("read 0x%03h", addr));
    check_word(data, exp, $sformatf("read 0x%03h", addr));
  endtask

  task automatic wait_periods(input int n);
    repeat (n * PERIOD) @(posedge clk_l);
    #1;
  endtask

  // first sample is taken now, the rest on the next 255 falling edges.
  task automatic measure_pulse(input int pin, output int high, output int rise);
    logic s [PERIOD];
    high = 0;
    rise = -1;
    for (int t = 0; t < PERIOD; t++) begin
      if (t > 0) @(negedge clk_l);
      s[t] = xdcr_out[pin];
    end
    for (int t = 0; t < PERIOD; t++) begin
      if (s[t]) high = high + 1;
      if (s[t] && !s[(t + PERIOD - 1) % PERIOD]) rise = t;
    end
  endtask

  // returns on the falling edge of the first high sample.
  task automatic wait_rise(input int pin);
    int   n;
    logic prev;
    n = 0;
    @(negedge clk_l);
    prev = xdcr_out[pin];
    @(negedge clk_l);
    while (!(xdcr_out[pin] && !prev)) begin
      n = n + 1;
      if (n > 4 * PERIOD) wait_expired($sformatf("a rising edge on pin %0d", pin));
      prev = xdcr_out[pin];
      @(negedge clk_l);
    end
  endtask

  task automatic test_readback();
    usonic_pkg::resp_e resp;
    logic [31:0]       data;
    write_reg('h000, 32'h3);
    read_expect('h000, 32'h3);
    write_reg('h004, 32'h5a);
    read_expect('h004, 32'h5a);
    write_reg('h008, 32'h3);
    read_expect('h008, 32'h3);
    write_reg('h10c, 32'ha57e);
    read_expect('h10c, 32'ha57e);
    write_reg('h214, 32'h99);
    read_expect('h214, 32'h99);
    axi_write('h00c, 32'hdead, resp);
    check_resp(resp, usonic_pkg::SLVERR, "unmapped write");
    axi_read('h00c, data, resp);
    check_resp(resp, usonic_pkg::SLVERR, "unmapped read");
    write_reg('h000, 32'h0);
    write_reg('h004, 32'h0);
  endtask

  task automatic test_out_en();
    int high;
    int rise;
    for (int i = 0; i < N; i++) begin
      rng_state = lcg_next(rng_state);
      duty_prog[i] = (rng_state[23:16] == '0) ? 8'd1 : rng_state[23:16];
      write_reg('h100 + 4 * i, {16'h0, rng_state[15:8], duty_prog[i]});
    end
    wait_periods(2);
    @(negedge clk_l);
    for (int t = 0; t < PERIOD; t++) begin
      if (xdcr_out !== '0) report_mismatch("pin high while output disabled");
      @(negedge clk_l);
    end
    write_reg('h000, 32'h1);
    wait_periods(2);
    for (int i = 0; i < N; i++) begin
      @(negedge clk_l);
      measure_pulse(i, high, rise);
      check_duty(high[W-1:0], duty_prog[i], $sformatf("pin %0d duty", i));
    end
  endtask

  task automatic test_phase();
    int           high;
    int           rise_p;
    int           rise_q;
    logic [W-1:0] diff;
    write_reg('h104, {16'h0, 8'd200, 8'd100});
    write_reg('h108, {16'h0, 8'd30, 8'd100});
    duty_prog[1] = 8'd100;
    duty_prog[2] = 8'd100;
    wait_periods(2);
    @(negedge clk_l);
    measure_pulse(1, high, rise_p);
    @(negedge clk_l);
    measure_pulse(2, high, rise_q);
    if (rise_p < 0 || rise_q < 0) report_mismatch("no rising edge on a phased pin");
    diff = rise_p - rise_q;
    check_duty(diff, 8'd170, "rising edge offset of pins 1 and 2");
  endtask

  task automatic test_modulation();
    int high;
    int rise;
    for (int k = 0; k < `USN_MOD_DEPTH; k++) write_reg('h200 + 4 * k, 32'd128);
    write_reg('h000, 32'h3);
    wait_periods(3);
    for (int i = 0; i < N; i++) begin
      @(negedge clk_l);
      measure_pulse(i, high, rise);
      check_duty(high[W-1:0], duty_prog[i] >> 1, $sformatf("pin %0d modulated duty", i));
    end
    write_reg('h000, 32'h1);
  endtask

  task automatic test_silencer();
    int high;
    int rise;
    int prev_w;
    bit reached;
    write_reg('h004, 32'h0);
    write_reg('h100, 32'h0);
    wait_periods(2);
    write_reg('h004, 32'h4);
    write_reg('h100, 32'd40);
    wait_rise(0);
    prev_w = 0;
    reached = 1'b0;
    for (int p = 0; p < 10; p++) begin
      if (p > 0) @(negedge clk_l);
      measure_pulse(0, high, rise);
      if (high < prev_w) report_mismatch($sformatf("silenced width fell to %0d", high));
      if (high > prev_w + 4) report_mismatch($sformatf("silenced width jumped to %0d", high));
      if (high == 40) reached = 1'b1;
      prev_w = high;
    end
    if (!reached) report_mismatch("silenced duty missed 40 within 10 periods");
    write_reg('h004, 32'h0);
  endtask

  task automatic test_backpressure();
    int n;
    @(posedge clk_l);
    #1;
    awaddr = 'h004;
    wdata = 32'h0;
    awvalid = 1'b1;
    wvalid = 1'b1;
    bready = 1'b0;
    n = 0;
    @(negedge clk_l);
    while (!awready) begin
      n = n + 1;
      if (n > TIMEOUT) wait_expired("awready");
      @(negedge clk_l);
    end
    @(posedge clk_l);
    #1;
    awvalid = 1'b0;
    wvalid = 1'b0;
    araddr = 'h000;
    arvalid = 1'b1;
    rready = 1'b1;
    for (int c = 0; c < 20; c++) begin
      @(negedge clk_l);
      if (!bvalid) report_mismatch("bvalid dropped while bready low");
      if (arready) report_mismatch("read accepted during a held write response");
    end
    @(posedge clk_l);
    #1;
    bready = 1'b1;
    @(negedge clk_l);
    check_resp(usonic_pkg::resp_e'(bresp), usonic_pkg::OKAY, "held write response");
    @(posedge clk_l);
    #1;
    bready = 1'b0;
    n = 0;
    @(negedge clk_l);
    while (!arready) begin
      n = n + 1;
      if (n > TIMEOUT) wait_expired("arready after back-pressure");
      @(negedge clk_l);
    end
    @(posedge clk_l);
    #1;
    arvalid = 1'b0;
    n = 0;
    @(negedge clk_l);
    while (!rvalid) begin
      n = n + 1;
      if (n > TIMEOUT) wait_expired("rvalid after back-pressure");
      @(negedge clk_l);
    end
    check_resp(usonic_pkg::resp_e'(rresp), usonic_pkg::OKAY, "read after back-pressure");
    check_word(rdata, 32'h1, "read after back-pressure");
    @(posedge clk_l);
    #1;
    rready = 1'b0;
  endtask

  initial begin
    clk_l = 1'b0;
    arst_n = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = 4'h0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    rng_state = 32'd74417;
    repeat (4) @(posedge clk_l);
    #1;
    arst_n = 1'b1;
    test_readback();
    test_out_en();
    test_phase();
    test_modulation();
    test_silencer();
    test_backpressure();
    $display("sim passed");
    $finish;
  end

endmodule

// File: usonic.f
+incdir+include
verilog/usonic_pkg.sv
verilog/table_wr_if.sv
verilog/usonic_ctrl.sv
verilog/focus_table.sv
verilog/amp_modulator.sv
verilog/duty_silencer.sv
verilog/pwm_gen.sv
verilog/usonic_top.sv
sim/usonic_tb.sv

// File: verilog/amp_modulator.sv
/* duty scaling by a stepped amplitude table; output is registered and
   phase passes unchanged. index restarts at 0 while modulation is off. */
`timescale 1ns/100ps
`include "usonic_defines.svh"

module amp_modulator (
  input  logic                   clk_l,
  input  logic                   arst_n,
  input  logic                   period_start,
  input  logic                   mod_en,
  input  logic [`USN_WIDTH-1:0]  mod_div,
  table_wr_if.mod                tbl,
  input  usonic_pkg::drive_vec_t drive_in,
  output usonic_pkg::drive_vec_t drive_out
);

  localparam int W = `USN_WIDTH;
  localparam int MW = $clog2(`USN_MOD_DEPTH);

  logic [W-1:0]   mod_mem [`USN_MOD_DEPTH];
  logic [MW-1:0]  mod_idx;
  logic [W-1:0]   div_cnt;
  logic [2*W-1:0] prod [`USN_NUM_XDCR];

  always_ff @(posedge clk_l or negedge arst_n) begin
    if (!arst_n) begin
      for (int k = 0; k < `USN_MOD_DEPTH; k++) mod_mem[k] <= '0;
    end else if (tbl.wr_en && tbl.region == usonic_pkg::REG_MOD) begin
      mod_mem[tbl.index[MW-1:0]] <= tbl.data[W-1:0];
    end
  end

  // index advances once every mod_div+1 periods.
  always_ff @(posedge clk_l or negedge arst_n) begin
    if (!arst_n) begin
      mod_idx <= '0;
      div_cnt <= '0;
    end else if (!mod_en) begin
      mod_idx <= '0;
      div_cnt <= '0;
    end else if (period_start) begin
      if (div_cnt == mod_div) begin
        div_cnt <= '0;
        mod_idx <= mod_idx + 1'b1;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `USN_NUM_XDCR; i++) begin
      prod[i] = drive_in[i].duty * mod_mem[mod_idx];
    end
  end

  always_ff @(posedge clk_l or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `USN_NUM_XDCR; i++) drive_out[i] <= '0;
    end else begin
      for (int i = 0; i < `USN_NUM_XDCR; i++) begin
        drive_out[i].phase <= drive_in[i].phase;
        drive_out[i].duty  <= mod_en ? prod[i][2*W-1:W] : drive_in[i].duty;
      end
    end
  end

endmodule

// File: verilog/duty_silencer.sv
/* duty slew limiter, one move per PWM period. step 0 disables limiting;
   phase is not limited. */
`timescale 1ns/100ps
`include "usonic_defines.svh"

module duty_silencer (
  input  logic                   clk_l,
  input  logic                   arst_n,
  input  logic                   period_start,
  input  logic [`USN_WIDTH-1:0]  step,
  input  usonic_pkg::drive_vec_t drive_in,
  output usonic_pkg::drive_vec_t drive_out
);

  usonic_pkg::duty_vec_t cur;
  usonic_pkg::duty_vec_t gap;

  always_comb begin
    for (int i = 0; i < `USN_NUM_XDCR; i++) begin
      gap[i] = (drive_in[i].duty > cur[i]) ? drive_in[i].duty - cur[i]
                                           : cur[i] - drive_in[i].duty;
    end
  end

  always_ff @(posedge clk_l or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `USN_NUM_XDCR; i++) cur[i] <= '0;
    end else if (period_start) begin
      for (int i = 0; i < `USN_NUM_XDCR; i++) begin
        if (step == '0 || gap[i] <= step) begin
          cur[i] <= drive_in[i].duty;
        end else if (drive_in[i].duty > cur[i]) begin
          cur[i] <= cur[i] + step;
        end else begin
          cur[i] <= cur[i] - step;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `USN_NUM_XDCR; i++) begin
      drive_out[i].duty  = cur[i];
      drive_out[i].phase = drive_in[i].phase;
    end
  end

  for (genvar g = 0; g < `USN_NUM_XDCR; g++) begin : g_slew_chk
    a_slew: assert property (@(posedge clk_l) disable iff (!arst_n)
      step != '0 |=> ((cur[g] >= $past(cur[g])) ? cur[g] - $past(cur[g])
                                                : $past(cur[g]) - cur[g]) <= $past(step));
  end

endmodule

// File: verilog/focus_table.sv
/* per-transducer focus storage, cleared by reset. */
`timescale 1ns/100ps
`include "usonic_defines.svh"

module focus_table (
  input  logic                   clk_l,
  input  logic                   arst_n,
  table_wr_if.focus              tbl,
  output usonic_pkg::drive_vec_t drive
);

  localparam int W = `USN_WIDTH;
  localparam int IW = $clog2(`USN_NUM_XDCR);

  logic hit;

  // decode keeps the index in range for this region.
  assign hit = tbl.wr_en && (tbl.region == usonic_pkg::REG_FOCUS);

  always_ff @(posedge clk_l or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `USN_NUM_XDCR; i++) begin
        drive[i] <= '0;
      end
    end else if (hit) begin
      // phase in 15:8, duty in 7:0.
      drive[tbl.index[IW-1:0]].phase <= tbl.data[2*W-1:W];
      drive[tbl.index[IW-1:0]].duty  <= tbl.data[W-1:0];
    end
  end

endmodule

// File: verilog/pwm_gen.sv
/* period of 2**USN_WIDTH clocks; drive is latched at count 0 and pins
   are registered, one clock behind the counter. */
`timescale 1ns/100ps
`include "usonic_defines.svh"

module pwm_gen (
  input  logic                     clk_l,
  input  logic                     arst_n,
  input  logic                     out_en,
  input  usonic_pkg::drive_vec_t   drive_in,
  output logic                     period_start,
  output logic [`USN_NUM_XDCR-1:0] xdcr_out
);

  logic [`USN_WIDTH-1:0]  cnt;
  logic [`USN_WIDTH-1:0]  rel [`USN_NUM_XDCR];
  usonic_pkg::drive_vec_t held;

  assign period_start = (cnt == '0);

  always_ff @(posedge clk_l or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
      for (int i = 0; i < `USN_NUM_XDCR; i++) held[i] <= '0;
    end else begin
      cnt <= cnt + 1'b1;
      if (period_start) held <= drive_in;
    end
  end

  // count relative to the phase, wraps modulo the period.
  always_comb begin
    for (int i = 0; i < `USN_NUM_XDCR; i++) rel[i] = cnt - held[i].phase;
  end

  always_ff @(posedge clk_l or negedge arst_n) begin
    if (!arst_n) begin
      xdcr_out <= '0;
    end else begin
      for (int i = 0; i < `USN_NUM_XDCR; i++) begin
        xdcr_out[i] <= out_en && (rel[i] < held[i].duty);
      end
    end
  end

endmodule

// File: verilog/table_wr_if.sv
/* one-cycle table write strobe; index is the word offset inside a region. */
`timescale 1ns/100ps

interface table_wr_if;

  logic                    wr_en;
  usonic_pkg::reg_region_e region;
  // word offset, byte address bits 7:2.
  logic [5:0]              index;
  logic [31:0]             data;

  modport ctrl (output wr_en, region, index, data);

  // focus table only acts on REG_FOCUS.
  modport focus (input wr_en, region, index, data);

  // modulator only acts on REG_MOD.
  modport mod (input wr_en, region, index, data);

endinterface

// File: verilog/usonic_ctrl.sv
/* AXI4-Lite slave, one transaction at a time. full-word writes only, wstrb
   is expected all ones; table reads come from local shadow copies. */
`timescale 1ns/100ps
`include "usonic_defines.svh"

module usonic_ctrl (
  input  logic                   clk_l,
  input  logic                   arst_n,
  input  logic [`USN_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  input  logic                   bready,
  input  logic [`USN_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  input  logic                   rready,
  output logic                   awready,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  output logic                   out_en,
  output logic                   mod_en,
  output logic [`USN_WIDTH-1:0]  step,
  output logic [`USN_WIDTH-1:0]  mod_div,
  table_wr_if.ctrl               tbl
);

  localparam int W = `USN_WIDTH;
  localparam int FI_W = $clog2(`USN_NUM_XDCR);
  localparam int MI_W = $clog2(`USN_MOD_DEPTH);

  usonic_pkg::axi_state_e  state;
  usonic_pkg::reg_region_e wr_region;
  usonic_pkg::reg_region_e rd_region;
  logic                    wr_go;
  logic                    rd_go;
  logic [31:0]             rd_word;
  logic [2*W-1:0]          focus_shadow [`USN_NUM_XDCR];
  logic [W-1:0]            mod_shadow [`USN_MOD_DEPTH];

  function automatic usonic_pkg::reg_region_e decode(input logic [`USN_ADDR_W-1:0] addr);
    logic [5:0] idx;
    idx = addr[7:2];
    decode = usonic_pkg::REG_NONE;
    if (addr == 'h000) decode = usonic_pkg::REG_CTRL;
    else if (addr == 'h004) decode = usonic_pkg::REG_STEP;
    else if (addr == 'h008) decode = usonic_pkg::REG_MOD_DIV;
    else if (addr[11:8] == 4'h1 && addr[1:0] == 2'b00 && idx < `USN_NUM_XDCR)
      decode = usonic_pkg::REG_FOCUS;
    else if (addr[11:8] == 4'h2 && addr[1:0] == 2'b00 && idx < `USN_MOD_DEPTH)
      decode = usonic_pkg::REG_MOD;
  endfunction

  assign wr_region = decode(awaddr);
  assign rd_region = decode(araddr);

  // a complete write wins over a waiting read.
  assign wr_go = (state == usonic_pkg::IDLE) && awvalid && wvalid;
  assign rd_go = (state == usonic_pkg::IDLE) && arvalid && !(awvalid && wvalid);

  assign awready = wr_go;
  assign wready  = wr_go;
  assign arready = rd_go;
  assign bvalid  = (state == usonic_pkg::WRITE_RESP);
  assign rvalid  = (state == usonic_pkg::READ_RESP);

  assign tbl.wr_en  = wr_go;
  assign tbl.region = wr_region;
  assign tbl.index  = awaddr[7:2];
  assign tbl.data   = wdata;

  always_ff @(posedge clk_l or negedge arst_n) begin
    if (!arst_n) begin
      state <= usonic_pkg::IDLE;
    end else begin
      case (state)
        usonic_pkg::IDLE: begin
          if (wr_go) state <= usonic_pkg::WRITE_RESP;
          else if (rd_go) state <= usonic_pkg::READ_RESP;
        end
        usonic_pkg::WRITE_RESP: if (bready) state <= usonic_pkg::IDLE;
        usonic_pkg::READ_RESP:  if (rready) state <= usonic_pkg::IDLE;
        default: state <= usonic_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_l or negedge arst_n) begin
    if (!arst_n) begin
      out_en  <= 1'b0;
      mod_en  <= 1'b0;
      step    <= '0;
      mod_div <= '0;
      for (int i = 0; i < `USN_NUM_XDCR; i++) focus_shadow[i] <= '0;
      for (int k = 0; k < `USN_MOD_DEPTH; k++) mod_shadow[k] <= '0;
    end else if (wr_go) begin
      case (wr_region)
        usonic_pkg::REG_CTRL: begin
          out_en <= wdata[0];
          mod_en <= wdata[1];
        end
        usonic_pkg::REG_STEP:    step <= wdata[W-1:0];
        usonic_pkg::REG_MOD_DIV: mod_div <= wdata[W-1:0];
        usonic_pkg::REG_FOCUS:   focus_shadow[awaddr[FI_W+1:2]] <= wdata[2*W-1:0];
        usonic_pkg::REG_MOD:     mod_shadow[awaddr[MI_W+1:2]] <= wdata[W-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_word = '0;
    case (rd_region)
      usonic_pkg::REG_CTRL:    rd_word[1:0] = {mod_en, out_en};
      usonic_pkg::REG_STEP:    rd_word[W-1:0] = step;
      usonic_pkg::REG_MOD_DIV: rd_word[W-1:0] = mod_div;
      usonic_pkg::REG_FOCUS:   rd_word[2*W-1:0] = focus_shadow[araddr[FI_W+1:2]];
      usonic_pkg::REG_MOD:     rd_word[W-1:0] = mod_shadow[araddr[MI_W+1:2]];
      default:                 rd_word = '0;
    endcase
  end

  // response payload, held while the FSM waits for ready.
  always_ff @(posedge clk_l) begin
    if (wr_go) begin
      bresp <= (wr_region == usonic_pkg::REG_NONE) ? usonic_pkg::SLVERR : usonic_pkg::OKAY;
    end
    if (rd_go) begin
      rdata <= rd_word;
      rresp <= (rd_region == usonic_pkg::REG_NONE) ? usonic_pkg::SLVERR : usonic_pkg::OKAY;
    end
  end

  a_bvalid_hold: assert property (@(posedge clk_l) disable iff (!arst_n)
    bvalid && !bready |=> bvalid);
  a_rvalid_hold: assert property (@(posedge clk_l) disable iff (!arst_n)
    rvalid && !rready |=> rvalid);
  a_one_resp: assert property (@(posedge clk_l) disable iff (!arst_n)
    !(bvalid && rvalid));
  // host must not issue partial writes.
  a_full_word: assert property (@(posedge clk_l) disable iff (!arst_n)
    wready |-> wstrb == 4'hf);

endmodule

// File: verilog/usonic_pkg.sv
/* shared types of the drive controller. drive_t keeps phase in the upper
   half so a focus register word maps onto it directly. */
`include "usonic_defines.svh"

package usonic_pkg;

  typedef struct packed {
    logic [`USN_WIDTH-1:0] phase;
    logic [`USN_WIDTH-1:0] duty;
  } drive_t;

  typedef drive_t drive_vec_t [`USN_NUM_XDCR];

  typedef logic [`USN_WIDTH-1:0] duty_vec_t [`USN_NUM_XDCR];

  // address decode regions.
  typedef enum logic [2:0] {
    REG_CTRL, REG_STEP, REG_MOD_DIV, REG_FOCUS, REG_MOD, REG_NONE
  } reg_region_e;

  typedef enum logic [1:0] {IDLE, WRITE_RESP, READ_RESP} axi_state_e;

  typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10} resp_e;

endpackage

// File: verilog/usonic_top.sv
/* drive controller top, single clock domain. AXI4-Lite slave with full-word
   writes only; pins stay low until out_en is set. */
`timescale 1ns/100ps
`include "usonic_defines.svh"

module usonic_top (
  input  logic                     clk_l,
  input  logic                     arst_n,
  input  logic [`USN_ADDR_W-1:0]   awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [31:0]              wdata,
  input  logic [3:0]               wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [`USN_ADDR_W-1:0]   araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [31:0]              rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready,
  output logic [`USN_NUM_XDCR-1:0] xdcr_out
);

  logic                   out_en;
  logic                   mod_en;
  logic [`USN_WIDTH-1:0]  step;
  logic [`USN_WIDTH-1:0]  mod_div;
  logic                   period_start;
  usonic_pkg::drive_vec_t drive_focus;
  usonic_pkg::drive_vec_t drive_mod;
  usonic_pkg::drive_vec_t drive_sil;

  table_wr_if tbl_if ();

  usonic_ctrl usonic_ctrl_inst (
    .clk_l, .arst_n, .awaddr, .awvalid, .wdata, .wstrb, .wvalid, .bready,
    .araddr, .arvalid, .rready, .awready, .wready, .bresp, .bvalid, .arready,
    .rdata, .rresp, .rvalid, .out_en, .mod_en, .step, .mod_div,
    .tbl(tbl_if.ctrl)
  );

  focus_table focus_table_inst (
    .clk_l, .arst_n, .tbl(tbl_if.focus), .drive(drive_focus)
  );

  amp_modulator amp_modulator_inst (
    .clk_l, .arst_n, .period_start, .mod_en, .mod_div, .tbl(tbl_if.mod),
    .drive_in(drive_focus), .drive_out(drive_mod)
  );

  duty_silencer duty_silencer_inst (
    .clk_l, .arst_n, .period_start, .step,
    .drive_in(drive_mod), .drive_out(drive_sil)
  );

  pwm_gen pwm_gen_inst (
    .clk_l, .arst_n, .out_en, .drive_in(drive_sil), .period_start, .xdcr_out
  );

endmodule
